//--- design/egress_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared sizes, port number type and FSM state encodings of the
// egress router
////////////////////////////////////////////////////////////////////////////

package egress_pkg;

    // Ingress word geometry
    localparam int DATA_BYTES = 8;
    localparam int WORD_W     = DATA_BYTES * 8;

    // Output ports
    localparam int NUM_PORTS = 4;
    localparam int PORT_W    = $clog2(NUM_PORTS);

    // Store-and-forward buffer per port
    localparam int BUF_WORDS = 64;
    localparam int BUF_AW    = $clog2(BUF_WORDS);

    // Largest accepted packet, 32 words
    localparam int MAX_PKT_BYTES = 256;

    typedef logic [PORT_W-1:0] port_t;

    // Buffer write side
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_STORE,
        WR_DROP
    } wr_state_t;

    // Byte serializer
    typedef enum logic {
        SER_IDLE,
        SER_SEND
    } ser_state_t;

endpackage

//--- design/egress_demux.sv
////////////////////////////////////////////////////////////////////////////
// Ingress register and per-port write steering of packet words
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_demux (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             in_valid,
    input  logic                             in_last,
    input  logic [egress_pkg::WORD_W-1:0]     in_data,
    input  logic [egress_pkg::DATA_BYTES-1:0] in_keep,
    input  egress_pkg::port_t                in_port,
    output logic [egress_pkg::NUM_PORTS-1:0]  wr_en,
    output logic [egress_pkg::WORD_W-1:0]     wr_data,
    output logic [egress_pkg::DATA_BYTES-1:0] wr_keep,
    output logic                             wr_last
);

    import egress_pkg::*;

    // High when the next valid word opens a new packet
    logic  first_word;
    port_t cur_port;
    port_t port_sel;

    // The port number only counts on the first word of a packet
    assign port_sel = first_word ? in_port : cur_port;

    ////////////////////////////////////////////////////////////////////////
    // Packet framing and port tracking

    always_ff @(posedge clk) begin
        if (reset) begin
            first_word <= 1'b1;
            cur_port   <= '0;
            wr_en      <= '0;
        end else begin
            if (in_valid) begin
                first_word <= in_last;
                cur_port   <= port_sel;
            end
            // One-hot enable, one cycle behind the ingress word
            wr_en <= in_valid ? (NUM_PORTS'(1) << port_sel) : '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Word payload register

    always_ff @(posedge clk) begin
        if (in_valid) begin
            wr_data <= in_data;
            wr_keep <= in_keep;
            wr_last <= in_last;
        end
    end

endmodule

//--- design/packet_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Store-and-forward packet memory with commit on last, rollback and
// overflow reporting on a full write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module packet_buffer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wr_en,
    input  logic                             wr_last,
    input  logic [egress_pkg::WORD_W-1:0]     wr_data,
    input  logic [egress_pkg::DATA_BYTES-1:0] wr_keep,
    input  logic                             rd_ready,
    output logic                             rd_valid,
    output logic                             rd_last,
    output logic [egress_pkg::WORD_W-1:0]     rd_data,
    output logic [egress_pkg::DATA_BYTES-1:0] rd_keep,
    output logic                             overflow
);

    import egress_pkg::*;

    // Word memory with keep and last stored beside each word
    logic [WORD_W-1:0]     mem_data [BUF_WORDS];
    logic [DATA_BYTES-1:0] mem_keep [BUF_WORDS];
    logic                  mem_last [BUF_WORDS];

    // Pointers carry one extra wrap bit so a full buffer differs from an empty one
    logic [BUF_AW:0] commit_ptr;
    logic [BUF_AW:0] work_ptr;
    logic [BUF_AW:0] rd_ptr;
    logic [BUF_AW:0] used;

    wr_state_t wr_state;

    logic full;
    logic wr_take;
    logic wr_reject;
    logic rd_fire;

    assign used = work_ptr - rd_ptr;
    assign full = (used == (BUF_AW + 1)'(BUF_WORDS));

    // Words are only looked at outside a dropped packet
    assign wr_take   = wr_en && (wr_state != WR_DROP) && !full;
    assign wr_reject = wr_en && (wr_state != WR_DROP) && full;

    ////////////////////////////////////////////////////////////////////////
    // Write side FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_state   <= WR_IDLE;
            work_ptr   <= '0;
            commit_ptr <= '0;
            overflow   <= 1'b0;
        end else begin
            overflow <= wr_reject;
            case (wr_state)
                WR_IDLE, WR_STORE: begin
                    if (wr_reject) begin
                        // Discard the partial packet, committed space stays intact
                        work_ptr <= commit_ptr;
                        wr_state <= wr_last ? WR_IDLE : WR_DROP;
                    end else if (wr_take) begin
                        work_ptr <= work_ptr + 1'b1;
                        if (wr_last) begin
                            commit_ptr <= work_ptr + 1'b1;
                            wr_state   <= WR_IDLE;
                        end else begin
                            wr_state <= WR_STORE;
                        end
                    end
                end
                WR_DROP: begin
                    // Ignore the rest of the packet
                    if (wr_en && wr_last) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // Memory write
    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem_data[work_ptr[BUF_AW-1:0]] <= wr_data;
            mem_keep[work_ptr[BUF_AW-1:0]] <= wr_keep;
            mem_last[work_ptr[BUF_AW-1:0]] <= wr_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read side

    // Only committed words are visible to the reader
    assign rd_valid = (rd_ptr != commit_ptr);
    assign rd_fire  = rd_valid && rd_ready;

    assign rd_data = mem_data[rd_ptr[BUF_AW-1:0]];
    assign rd_keep = mem_keep[rd_ptr[BUF_AW-1:0]];
    assign rd_last = mem_last[rd_ptr[BUF_AW-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- design/port_serializer.sv
////////////////////////////////////////////////////////////////////////////
// Word to byte conversion with a byte valid/ready output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module port_serializer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rd_valid,
    input  logic                             rd_last,
    input  logic [egress_pkg::WORD_W-1:0]     rd_data,
    input  logic [egress_pkg::DATA_BYTES-1:0] rd_keep,
    output logic                             rd_ready,
    input  logic                             out_ready,
    output logic                             out_valid,
    output logic                             out_last,
    output logic [7:0]                       out_data
);

    import egress_pkg::*;

    ser_state_t state;

    // Word currently being sent
    logic [WORD_W-1:0]     word_data;
    logic [DATA_BYTES-1:0] word_keep;
    logic                  word_last;

    logic [$clog2(DATA_BYTES)-1:0] byte_idx;

    logic [DATA_BYTES-1:0] keep_rest;
    logic                  final_byte;
    logic                  byte_fire;
    logic                  word_done;
    logic                  load;

    // Keep bits from the current byte upwards; nothing above it means last kept byte
    assign keep_rest  = word_keep >> byte_idx;
    assign final_byte = (keep_rest[DATA_BYTES-1:1] == '0);

    assign out_valid = (state == SER_SEND);
    assign out_data  = word_data[byte_idx*8 +: 8];
    assign out_last  = out_valid && word_last && final_byte;

    assign byte_fire = out_valid && out_ready;
    assign word_done = byte_fire && final_byte;

    // Next word is requested while idle or as the last kept byte leaves
    assign rd_ready = (state == SER_IDLE) || word_done;
    assign load     = rd_valid && rd_ready;

    ////////////////////////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= SER_IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                SER_IDLE: begin
                    if (load) begin
                        state    <= SER_SEND;
                        byte_idx <= '0;
                    end
                end
                SER_SEND: begin
                    if (word_done) begin
                        byte_idx <= '0;
                        state    <= load ? SER_SEND : SER_IDLE;
                    end else if (byte_fire) begin
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
                default: begin
                    state <= SER_IDLE;
                end
            endcase
        end
    end

    // Word holding register
    always_ff @(posedge clk) begin
        if (load) begin
            word_data <= rd_data;
            word_keep <= rd_keep;
            word_last <= rd_last;
        end
    end

endmodule

//--- design/egress_router.sv
////////////////////////////////////////////////////////////////////////////
// Egress router top: demux, per-port packet buffers and byte serializers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_router (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  logic [egress_pkg::WORD_W-1:0]       in_data,
    input  logic [egress_pkg::DATA_BYTES-1:0]   in_keep,
    input  logic                               in_last,
    input  egress_pkg::port_t                  in_port,
    input  logic [egress_pkg::NUM_PORTS-1:0]    out_ready,
    output logic [egress_pkg::NUM_PORTS-1:0]    out_valid,
    output logic [egress_pkg::NUM_PORTS-1:0]    out_last,
    output logic [egress_pkg::NUM_PORTS*8-1:0]  out_data,
    output logic [egress_pkg::NUM_PORTS-1:0]    overflow
);

    import egress_pkg::*;

    // Demux to buffers
    logic [NUM_PORTS-1:0]  wr_en;
    logic [WORD_W-1:0]     wr_data;
    logic [DATA_BYTES-1:0] wr_keep;
    logic                  wr_last;

    // Buffers to serializers
    logic [NUM_PORTS-1:0]  rd_valid;
    logic [NUM_PORTS-1:0]  rd_ready;
    logic [NUM_PORTS-1:0]  rd_last;
    logic [WORD_W-1:0]     rd_data [NUM_PORTS];
    logic [DATA_BYTES-1:0] rd_keep [NUM_PORTS];

    egress_demux u_demux (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_last  (in_last),
        .in_data  (in_data),
        .in_keep  (in_keep),
        .in_port  (in_port),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .wr_keep  (wr_keep),
        .wr_last  (wr_last)
    );

    ////////////////////////////////////////////////////////////////////////
    // One buffer and serializer per output port

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        packet_buffer u_buffer (
            .clk      (clk),
            .reset    (reset),
            .wr_en    (wr_en[p]),
            .wr_last  (wr_last),
            .wr_data  (wr_data),
            .wr_keep  (wr_keep),
            .rd_ready (rd_ready[p]),
            .rd_valid (rd_valid[p]),
            .rd_last  (rd_last[p]),
            .rd_data  (rd_data[p]),
            .rd_keep  (rd_keep[p]),
            .overflow (overflow[p])
        );

        // Byte lane p of out_data
        port_serializer u_serializer (
            .clk       (clk),
            .reset     (reset),
            .rd_valid  (rd_valid[p]),
            .rd_last   (rd_last[p]),
            .rd_data   (rd_data[p]),
            .rd_keep   (rd_keep[p]),
            .rd_ready  (rd_ready[p]),
            .out_ready (out_ready[p]),
            .out_valid (out_valid[p]),
            .out_last  (out_last[p]),
            .out_data  (out_data[p*8 +: 8])
        );

    end

endmodule

//--- sim/egress_router_tb.sv
////////////////////////////////////////////////////////////////////////////
// Egress router testbench with LFSR stimulus and a per-port byte model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module egress_router_tb;

    import egress_pkg::*;

    localparam int TOTAL_PKTS     = 2 + 150 + 150 + 8 + 20;
    localparam int TIMEOUT_CYCLES = 4 * (TOTAL_PKTS * (MAX_PKT_BYTES + 40));
    localparam int DROP_WORDS     = BUF_WORDS / 4;

    logic                   clk_ifc;
    logic                   reset;
    logic                   in_valid;
    logic [WORD_W-1:0]      in_data;
    logic [DATA_BYTES-1:0]  in_keep;
    logic                   in_last;
    port_t                  in_port;
    logic [NUM_PORTS-1:0]   out_ready;
    logic [NUM_PORTS-1:0]   out_valid;
    logic [NUM_PORTS-1:0]   out_last;
    logic [NUM_PORTS*8-1:0] out_data;
    logic [NUM_PORTS-1:0]   overflow;

    // Reference model of expected bytes and packet lengths per port
    logic [7:0]           byte_q [NUM_PORTS][$];
    int                   len_q [NUM_PORTS][$];
    int                   rem_bytes [NUM_PORTS];
    int                   outstanding [NUM_PORTS];
    int                   ovf_count [NUM_PORTS];
    logic [NUM_PORTS-1:0] ovf_prev;
    logic [NUM_PORTS-1:0] ovf_allowed;

    logic [31:0] lfsr;
    logic        bp_on;
    logic        hold_port0;
    int          cycle_count;

    egress_router UUT (
        .clk       (clk_ifc),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_keep   (in_keep),
        .in_last   (in_last),
        .in_port   (in_port),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_data  (out_data),
        .overflow  (overflow)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #4 clk_ifc = ~clk_ifc;
    end

    ////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // Next drive point that also refreshes the sink ready pattern
    task automatic tick();
        @(posedge clk_ifc);
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (hold_port0 && p == 0) begin
                out_ready[p] = 1'b0;
            end else if (bp_on) begin
                out_ready[p] = (take_bits(2) != 32'd0);
            end else begin
                out_ready[p] = 1'b1;
            end
        end
    endtask

    task automatic drive_idle();
        tick();
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic send_packet(input port_t port, input int len, input logic kept);
        logic [7:0] bytes [MAX_PKT_BYTES];
        int         n_words;
        int         idx;
        n_words = (len + DATA_BYTES - 1) / DATA_BYTES;
        for (int i = 0; i < len; i++) begin
            bytes[i] = 8'(take_bits(8));
        end
        if (kept) begin
            for (int i = 0; i < len; i++) begin
                byte_q[port].push_back(bytes[i]);
            end
            len_q[port].push_back(len);
            outstanding[port]++;
        end
        for (int w = 0; w < n_words; w++) begin
            tick();
            in_valid = 1'b1;
            in_last  = (w == n_words - 1);
            // Later words carry a wrong port that the demux must ignore
            in_port  = (w == 0) ? port : port_t'(port + 1);
            for (int b = 0; b < DATA_BYTES; b++) begin
                idx               = w * DATA_BYTES + b;
                in_keep[b]        = (idx < len);
                in_data[b*8 +: 8] = (idx < len) ? bytes[idx] : 8'hee;
            end
        end
    endtask

    task automatic wait_drained();
        int busy;
        busy = 1;
        while (busy != 0) begin
            drive_idle();
            busy = 0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (outstanding[p] != 0 || byte_q[p].size() != 0) busy = 1;
            end
        end
    endtask

    // One packet in flight per port at most
    task automatic random_packets(input int count);
        port_t port;
        int    len;
        for (int i = 0; i < count; i++) begin
            port = port_t'(take_bits(PORT_W));
            len  = int'(take_bits(8)) % MAX_PKT_BYTES + 1;
            while (outstanding[port] != 0) drive_idle();
            send_packet(port, len, 1'b1);
        end
        wait_drained();
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Output monitor and timeout

    always @(posedge clk_ifc) begin
        logic [7:0] exp_byte;
        if (!reset) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (overflow[p]) begin
                    check($sformatf("overflow[%0d]", p), 64'(ovf_allowed[p]), 64'(1));
                    check($sformatf("overflow[%0d] one cycle earlier", p),
                          64'(ovf_prev[p]), 64'(0));
                    ovf_count[p]++;
                end
                if (out_valid[p] && out_ready[p]) begin
                    if (byte_q[p].size() == 0) begin
                        abort_run($sformatf("port %0d sent a byte that was never expected", p));
                    end else begin
                        if (rem_bytes[p] == 0) rem_bytes[p] = len_q[p].pop_front();
                        exp_byte = byte_q[p].pop_front();
                        check($sformatf("out_data[%0d]", p),
                              64'(out_data[p*8 +: 8]), 64'(exp_byte));
                        check($sformatf("out_last[%0d]", p),
                              64'(out_last[p]), 64'(rem_bytes[p] == 1));
                        rem_bytes[p]--;
                        if (rem_bytes[p] == 0) outstanding[p]--;
                    end
                end
            end
        end
        ovf_prev = overflow;
    end

    always @(posedge clk_ifc) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        lfsr        = 32'h7edc23b8;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_data     = '0;
        in_keep     = '0;
        in_last     = 1'b0;
        in_port     = '0;
        out_ready   = '1;
        bp_on       = 1'b0;
        hold_port0  = 1'b0;
        ovf_allowed = '0;
        ovf_prev    = '0;
        cycle_count = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rem_bytes[p]   = 0;
            outstanding[p] = 0;
            ovf_count[p]   = 0;
        end
        repeat (3) tick();
        reset = 1'b0;
        check("out_valid", 64'(out_valid), 64'(0));
        check("overflow", 64'(overflow), 64'(0));

        // Integrity and framing with a single byte and one full word first
        send_packet(port_t'(1), 1, 1'b1);
        send_packet(port_t'(2), DATA_BYTES, 1'b1);
        random_packets(150);

        // Same traffic under random sink back-pressure
        bp_on = 1'b1;
        random_packets(150);
        bp_on = 1'b0;

        // Only the first four packets fit while port 0 is stalled
        hold_port0  = 1'b1;
        ovf_allowed = NUM_PORTS'(1);
        for (int i = 0; i < 8; i++) begin
            send_packet(port_t'(0), DROP_WORDS * DATA_BYTES, i < 4);
        end
        repeat (4) drive_idle();
        check("overflow[0] pulse count", 64'(ovf_count[0]), 64'(4));
        hold_port0 = 1'b0;
        wait_drained();
        ovf_allowed = '0;

        // Recovery
        random_packets(20);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- egress_router.f
design/egress_pkg.sv
design/egress_demux.sv
design/packet_buffer.sv
design/port_serializer.sv
design/egress_router.sv
sim/egress_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the egress router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module egress_router_tb \
    -f egress_router.f -o egress_router_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/egress_router_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi

echo "Simulation run did not pass (status $run_status), see $LOG"
exit 1
